// File: include/trim_settings.svh
// Oscillator trim settings: code and period widths, loop target, first step, synchronizer depth.
`ifndef TRIM_SETTINGS_SVH
`define TRIM_SETTINGS_SVH

// ========================================
// widths.
// ========================================
`define TRIM_WIDTH 7
`define PERIOD_WIDTH 9

// ========================================
// trim loop.
// ========================================
// system cycles wanted per reference period.
`define TRIM_TARGET_PERIOD 255
`define TRIM_STEP_INIT 15
`define TRIM_RESET_CODE 64

// flops in the reference clock synchronizer.
`define SYNC_STAGES 2

`endif

// File: logic/trim_pkg.sv
// Oscillator trim types: trim code, measured period, step size and trim FSM states.
package trim_pkg;

	`include "trim_settings.svh"

	// ========================================
	// payload types.
	// ========================================

	// code applied to the oscillator.
	typedef logic [`TRIM_WIDTH-1:0] trim_code_t;

	// system cycles between two reference edges.
	typedef logic [`PERIOD_WIDTH-1:0] period_t;

	// adjustment applied per measurement, 15 down to 1.
	typedef logic [3:0] step_t;

	// ========================================
	// trim FSM.
	// ========================================
	typedef enum logic [1:0] {
		IDLE,
		START,
		TRIMMING,
		STOPPED
	} trim_state_e;

endpackage

// File: logic/trim_meas_if.sv
// Period measurement link: one reference period handed from the counter to the trim FSM.
`timescale 1ns/1ps

interface trim_meas_if
	import trim_pkg::*;
	();

	logic valid;
	logic ready;
	period_t period;
	// count ran into its ceiling before the edge came.
	logic saturated;

	modport producer (
		output valid,
		output period,
		output saturated,
		input ready
	);

	modport consumer (
		input valid,
		input period,
		input saturated,
		output ready
	);

endinterface

// File: logic/trim_code_if.sv
// Trim code link: code updates from the trim FSM to the register that holds the code.
`timescale 1ns/1ps

interface trim_code_if
	import trim_pkg::*;
	();

	trim_code_t code;
	trim_code_t next_code;
	// load next_code on the coming edge.
	logic set;
	// a trim is running, host writes are held off.
	logic busy;

	modport controller (
		input code,
		output next_code,
		output set,
		output busy
	);

	modport holder (
		output code,
		input next_code,
		input set,
		input busy
	);

endinterface

// File: logic/clkref_sync.sv
// Reference clock synchronizer: samples the external reference and pulses once per rising edge.
`timescale 1ns/1ps
`include "trim_settings.svh"

module clkref_sync (
	input logic clk_rst,
	input logic rst_n,
	input logic clkref,
	output logic ref_rise
);

	logic [`SYNC_STAGES-1:0] sync_q;
	logic ref_hist;

	// sync_q[0] is the only flop that may go metastable.
	always_ff @(posedge clk_rst or negedge rst_n) begin
		if (!rst_n) begin
			sync_q <= '0;
			ref_hist <= 1'b0;
			ref_rise <= 1'b0;
		end
		else begin
			sync_q <= {sync_q[`SYNC_STAGES-2:0], clkref};
			ref_hist <= sync_q[`SYNC_STAGES-1];
			// registered so the pulse is clean for the counter.
			ref_rise <= sync_q[`SYNC_STAGES-1] & ~ref_hist;
		end
	end

endmodule

// File: logic/period_counter.sv
// Reference period counter: counts system cycles between reference edges and offers each count.
`timescale 1ns/1ps

module period_counter
	import trim_pkg::*;
	(
	input logic clk_rst,
	input logic rst_n,
	input logic ref_rise,
	trim_meas_if.producer meas
);

	period_t cnt_q;

	// ========================================
	// cycle counter and valid flag.
	// ========================================
	always_ff @(posedge clk_rst or negedge rst_n) begin
		if (!rst_n) begin
			cnt_q <= '0;
			meas.valid <= 1'b0;
		end
		else begin
			if (ref_rise) begin
				// the edge cycle itself is the first cycle of the new period.
				cnt_q <= period_t'(1);
				// a pending count is simply replaced.
				meas.valid <= 1'b1;
			end
			else begin
				if (cnt_q != '1) begin
					cnt_q <= cnt_q + period_t'(1);
				end
				if (meas.valid && meas.ready) begin
					meas.valid <= 1'b0;
				end
			end
		end
	end

	// ========================================
	// captured measurement.
	// ========================================
	always_ff @(posedge clk_rst) begin
		if (ref_rise) begin
			meas.period <= cnt_q;
			meas.saturated <= (cnt_q == '1);
		end
	end

endmodule

// File: logic/trim_register.sv
// Trim code register: holds the oscillator code, loaded by the trim FSM or by a host write.
`timescale 1ns/1ps
`include "trim_settings.svh"

module trim_register
	import trim_pkg::*;
	(
	input logic clk_rst,
	input logic rst_n,
	input logic wr_valid,
	input trim_code_t wr_data,
	output logic wr_ready,
	trim_code_if.holder tc
);

	trim_code_t code_q;

	// host is locked out for the whole trim.
	assign wr_ready = ~tc.busy;

	always_ff @(posedge clk_rst or negedge rst_n) begin
		if (!rst_n) begin
			code_q <= trim_code_t'(`TRIM_RESET_CODE);
		end
		else begin
			if (tc.set) begin
				code_q <= tc.next_code;
			end
			else if (wr_valid && wr_ready) begin
				code_q <= wr_data;
			end
		end
	end

	assign tc.code = code_q;

endmodule

// File: logic/trim_controller.sv
// Auto-trim FSM: successive approximation of the trim code with a halving step and saturation.
`timescale 1ns/1ps
`include "trim_settings.svh"

module trim_controller
	import trim_pkg::*;
	(
	input logic clk_rst,
	input logic rst_n,
	input logic auto_trim_enable,
	trim_meas_if.consumer meas,
	trim_code_if.controller tc,
	output logic trim_done
);

	localparam trim_code_t CODE_MAX = '1;
	localparam period_t TARGET = period_t'(`TRIM_TARGET_PERIOD);

	trim_state_e state_q, state_d;
	step_t step_q, step_d;
	logic dir_up_q, dir_up_d;
	logic discard_q, discard_d;

	logic take;
	logic above, below, at_target;
	logic reverse, push_bound;
	step_t step_move;
	trim_code_t step_ext, code_up, code_dn;

	// ========================================
	// measurement decode.
	// ========================================
	assign take = meas.valid & meas.ready;
	assign above = meas.saturated | (meas.period > TARGET);
	assign below = ~above & (meas.period < TARGET);
	assign at_target = ~above & ~below;
	assign reverse = (above & dir_up_q) | (below & ~dir_up_q);
	// pushing against a limit counts like a reversal, so the loop still ends.
	assign push_bound = (above & (tc.code == '0)) | (below & (tc.code == CODE_MAX));

	// a reversal already moves by the halved step.
	assign step_move = (reverse | push_bound) ? (step_q >> 1) : step_q;
	assign step_ext = trim_code_t'(step_move);
	assign code_up = (tc.code > CODE_MAX - step_ext) ? CODE_MAX : tc.code + step_ext;
	assign code_dn = (tc.code < step_ext) ? '0 : tc.code - step_ext;

	// ========================================
	// next state.
	// ========================================
	always_comb begin
		state_d = state_q;
		step_d = step_q;
		dir_up_d = dir_up_q;
		discard_d = discard_q;
		tc.set = 1'b0;
		tc.next_code = tc.code;
		case (state_q)
			IDLE: begin
				if (auto_trim_enable) begin
					state_d = START;
				end
			end
			START: begin
				tc.set = 1'b1;
				tc.next_code = '0;
				step_d = step_t'(`TRIM_STEP_INIT);
				dir_up_d = 1'b1;
				discard_d = 1'b1;
				state_d = TRIMMING;
			end
			TRIMMING: begin
				if (!auto_trim_enable) begin
					state_d = IDLE;
				end
				else if (take) begin
					if (discard_q) begin
						discard_d = 1'b0;
					end
					else if (step_q == step_t'(1) && (at_target || reverse || push_bound)) begin
						state_d = STOPPED;
					end
					else if (at_target) begin
						step_d = step_q >> 1;
					end
					else begin
						tc.set = 1'b1;
						tc.next_code = above ? code_dn : code_up;
						dir_up_d = below;
						step_d = step_move;
						// period running at the update still reflects the old code.
						discard_d = (tc.next_code != tc.code);
					end
				end
			end
			STOPPED: begin
				if (!auto_trim_enable) begin
					state_d = IDLE;
				end
			end
			default: begin
				state_d = IDLE;
			end
		endcase
	end

	always_ff @(posedge clk_rst or negedge rst_n) begin
		if (!rst_n) begin
			state_q <= IDLE;
			step_q <= step_t'(`TRIM_STEP_INIT);
			dir_up_q <= 1'b1;
			discard_q <= 1'b0;
		end
		else begin
			state_q <= state_d;
			step_q <= step_d;
			dir_up_q <= dir_up_d;
			discard_q <= discard_d;
		end
	end

	// ========================================
	// outputs.
	// ========================================
	assign tc.busy = (state_q == START) | (state_q == TRIMMING);
	assign meas.ready = (state_q == START) | (state_q == TRIMMING);
	assign trim_done = (state_q == STOPPED);

endmodule

// File: logic/osc_trim_top.sv
// Oscillator trim subsystem: reference sync, period counter, trim register and auto-trim FSM.
`timescale 1ns/1ps

module osc_trim_top
	import trim_pkg::*;
	(
	input logic clk_rst,
	input logic rst_n,
	input logic clkref,
	input logic auto_trim_enable,
	input logic wr_valid,
	input trim_code_t wr_data,
	output logic wr_ready,
	output trim_code_t trim_osc,
	output logic trim_busy,
	output logic trim_done
);

	logic ref_rise;

	trim_meas_if meas_bus ();
	trim_code_if code_bus ();

	clkref_sync u_clkref_sync (
		.clk_rst (clk_rst),
		.rst_n (rst_n),
		.clkref (clkref),
		.ref_rise (ref_rise)
	);

	period_counter u_period_counter (
		.clk_rst (clk_rst),
		.rst_n (rst_n),
		.ref_rise (ref_rise),
		.meas (meas_bus.producer)
	);

	trim_register u_trim_register (
		.clk_rst (clk_rst),
		.rst_n (rst_n),
		.wr_valid (wr_valid),
		.wr_data (wr_data),
		.wr_ready (wr_ready),
		.tc (code_bus.holder)
	);

	trim_controller u_trim_controller (
		.clk_rst (clk_rst),
		.rst_n (rst_n),
		.auto_trim_enable (auto_trim_enable),
		.meas (meas_bus.consumer),
		.tc (code_bus.controller),
		.trim_done (trim_done)
	);

	assign trim_osc = code_bus.code;
	assign trim_busy = code_bus.busy;

endmodule

// File: sim/tb_osc_trim.sv
// Oscillator trim testbench: reference oscillator model, host writes and auto-trim runs.
`timescale 1ns/1ps

module tb_osc_trim
	import trim_pkg::*;
	();

	localparam int TARGET = 255;
	localparam int WATCHDOG_NS = 4 * 40 * 400 * 4;
	localparam int DONE_LIMIT = 40 * 400;

	logic clk_rst, rst_n, clkref, auto_trim_enable;
	logic wr_valid, wr_ready, trim_busy, trim_done;
	trim_code_t wr_data, trim_osc;
	int osc_offset, ref_len, ref_left;
	int tests, checks, errors, test_start_errors;
	int unsigned lcg_state;
	string test_name;

	osc_trim_top uut (.*);

	// ========================================
	// helpers.
	// ========================================
	function automatic int unsigned lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state >> 16;
	endfunction

	function void count_failure(input string what);
		errors++;
		$display("%s: %s", test_name, what);
	endfunction

	task next_cycle();
		@(posedge clk_rst);
		#1;
	endtask

	task check_value(input int expected, input int actual);
		checks++;
		assert (actual == expected) else begin
			errors++;
			$display("error %s: expected %0d, actual %0d", test_name, expected, actual);
		end
	endtask

	task finish_test();
		tests++;
		$display("test %s finished with %0d errors", test_name, errors - test_start_errors);
		test_start_errors = errors;
	endtask

	// raise enable well before a reference edge, so the first kept period sees code 0.
	task start_trim(input int offset);
		osc_offset = offset;
		do @(posedge clk_rst); while (ref_left != 10);
		#1;
		auto_trim_enable = 1'b1;
	endtask

	task stop_trim();
		auto_trim_enable = 1'b0;
		next_cycle();
	endtask

	task wait_done();
		int n;
		n = 0;
		while (!trim_done && n < DONE_LIMIT) begin
			next_cycle();
			n++;
		end
		if (!trim_done) begin
			count_failure("trim_done did not rise before the cycle limit");
		end
	endtask

	// ========================================
	// clock, watchdog and oscillator model.
	// ========================================
	initial begin
		clk_rst = 1'b0;
		forever #2 clk_rst = ~clk_rst;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired before the tests finished");
		$display("Simulation failed");
		$finish;
	end

	// each reference period is offset + code system cycles, high for the first half.
	initial begin
		clkref = 1'b0;
		ref_len = 0;
		ref_left = 0;
		@(posedge rst_n);
		forever begin
			if (ref_left == 0) begin
				ref_len = osc_offset + int'(trim_osc);
				ref_left = ref_len;
			end
			clkref = (ref_left > ref_len / 2);
			ref_left--;
			next_cycle();
		end
	end

	assert property (@(posedge clk_rst) disable iff (!rst_n) wr_ready == !trim_busy)
		else count_failure("wr_ready is not the inverse of trim_busy");
	assert property (@(posedge clk_rst) disable iff (!rst_n) $rose(trim_busy) |=> trim_osc == '0)
		else count_failure("the first code of a new trim is not 0");
	assert property (@(posedge clk_rst) disable iff (!rst_n)
		(trim_busy && wr_valid) |=> trim_osc != $past(wr_data))
		else count_failure("a host write reached the code during a trim");

	// ========================================
	// tests.
	// ========================================
	initial begin
		int code;
		int period_err;
		lcg_state = 32'd95183;
		rst_n = 1'b0;
		auto_trim_enable = 1'b0;
		wr_valid = 1'b0;
		wr_data = '0;
		osc_offset = 200;
		tests = 0;
		checks = 0;
		errors = 0;
		test_start_errors = 0;
		test_name = "reset";
		repeat (2) @(posedge clk_rst);
		#1 rst_n = 1'b1;
		check_value(64, int'(trim_osc));
		check_value(0, int'(trim_busy));
		check_value(0, int'(trim_done));
		check_value(1, int'(wr_ready));
		finish_test();

		test_name = "host_write";
		repeat (4) begin
			code = int'(lcg_next() % 128);
			wr_valid = 1'b1;
			wr_data = trim_code_t'(code);
			check_value(1, int'(wr_ready));
			next_cycle();
			check_value(code, int'(trim_osc));
		end
		wr_valid = 1'b0;
		finish_test();

		test_name = "convergence";
		start_trim(140 + int'(lcg_next() % 101));
		wait_done();
		period_err = osc_offset + int'(trim_osc) - TARGET;
		checks++;
		assert (period_err >= -1 && period_err <= 1) else begin
			errors++;
			$display("error %s: expected %0d +-1, actual %0d", test_name, TARGET,
				osc_offset + int'(trim_osc));
		end
		finish_test();

		test_name = "saturation_high";
		stop_trim();
		start_trim(100);
		wait_done();
		check_value(127, int'(trim_osc));
		check_value(1, int'(trim_done));
		finish_test();

		// host keeps writing while the trim runs.
		test_name = "saturation_low";
		stop_trim();
		start_trim(300);
		next_cycle();
		wr_valid = 1'b1;
		wr_data = trim_code_t'(85);
		wait_done();
		wr_valid = 1'b0;
		check_value(0, int'(trim_osc));
		check_value(1, int'(trim_done));
		finish_test();

		test_name = "restart";
		stop_trim();
		check_value(0, int'(trim_done));
		check_value(0, int'(trim_busy));
		code = 1 + int'(lcg_next() % 127);
		wr_valid = 1'b1;
		wr_data = trim_code_t'(code);
		next_cycle();
		wr_valid = 1'b0;
		check_value(code, int'(trim_osc));
		start_trim(200);
		next_cycle();
		check_value(1, int'(trim_busy));
		next_cycle();
		check_value(0, int'(trim_osc));
		stop_trim();
		finish_test();

		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0) begin
			$display("Simulation completed successfully");
		end
		else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

// File: sim.f
+incdir+include
logic/trim_pkg.sv
logic/trim_meas_if.sv
logic/trim_code_if.sv
logic/clkref_sync.sv
logic/period_counter.sv
logic/trim_register.sv
logic/trim_controller.sv
logic/osc_trim_top.sv
sim/tb_osc_trim.sv

// File: Bender.yml
package:
  name: osc_trim

export_include_dirs:
  - include

sources:
  - logic/trim_pkg.sv
  - logic/trim_meas_if.sv
  - logic/trim_code_if.sv
  - logic/clkref_sync.sv
  - logic/period_counter.sv
  - logic/trim_register.sv
  - logic/trim_controller.sv
  - logic/osc_trim_top.sv
  - target: simulation
    files:
      - sim/tb_osc_trim.sv
